/* logic/board_pkg.sv */
package board_pkg;

  //////////////////////////////////////////////////
  // Memory path widths
  //////////////////////////////////////////////////

  localparam int soc_addr_w  = 48;
  localparam int dram_addr_w = 30;
  localparam int data_w      = 64;

  // Request as issued by the SoC
  typedef struct packed {
    logic [soc_addr_w-1:0] addr;
    logic                  we;
    logic [data_w-1:0]     wdata;
    logic [data_w/8-1:0]   strb;
  } soc_req_t;

  // Request after narrowing to the DRAM window
  typedef struct packed {
    logic [dram_addr_w-1:0] addr;
    logic                   we;
    logic [data_w-1:0]      wdata;
    logic [data_w/8-1:0]    strb;
  } dram_req_t;

  typedef struct packed {
    logic [data_w-1:0] rdata;
    logic              err;
  } mem_rsp_t;

  //////////////////////////////////////////////////
  // Board constants
  //////////////////////////////////////////////////

  // 50 MHz down to 1 MHz
  localparam int rtc_half_period = 25;
  localparam int rtc_cnt_w       = $clog2(rtc_half_period);

  // Short prescale keeps the PWM period at 64 cycles
  localparam int fan_prescale = 4;
  localparam int fan_pre_w    = $clog2(fan_prescale);

  localparam int sync_stages = 2;

endpackage

/* logic/spill_cut.sv */
module spill_cut #(
  parameter type payload_t = logic
) (
  input  logic     soc_clk,
  input  logic     rst_n,
  input  payload_t in_data_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output payload_t out_data_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  // Main slot drives the output, spill slot catches one extra item
  payload_t a_data_q;
  payload_t b_data_q;
  logic     a_full_q;
  logic     b_full_q;

  logic a_fire;
  logic in_fire;
  logic load_a_in;
  logic load_a_spill;
  logic load_b;

  assign a_fire  = a_full_q && out_ready_i;
  assign in_fire = in_valid_i && in_ready_o;

  // New item goes straight to main if it is empty or draining
  assign load_a_in    = in_fire && (!a_full_q || a_fire);
  assign load_a_spill = b_full_q && a_fire;
  assign load_b       = in_fire && a_full_q && !a_fire;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fire) begin
        a_full_q <= b_full_q;
      end
      if (load_a_in) begin
        a_full_q <= 1'b1;
      end
      if (load_b) begin
        b_full_q <= 1'b1;
      end else if (load_a_spill) begin
        b_full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge soc_clk) begin
    if (load_a_spill) begin
      a_data_q <= b_data_q;
    end else if (load_a_in) begin
      a_data_q <= in_data_i;
    end
    if (load_b) begin
      b_data_q <= in_data_i;
    end
  end

  // Ready comes from a flop only, no path from out_ready_i
  assign in_ready_o  = !b_full_q;
  assign out_valid_o = a_full_q;
  assign out_data_o  = a_data_q;

  // Stalled output holds valid and payload
  assert property (@(posedge soc_clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

  // No third item while both slots are occupied
  assert property (@(posedge soc_clk) disable iff (!rst_n)
    a_full_q && b_full_q |=> a_full_q && $stable(b_data_q));

endmodule

/* logic/rtc_divider.sv */
module rtc_divider (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  import board_pkg::*;

  logic [rtc_cnt_w-1:0] cnt_q;
  logic                 rtc_q;
  logic                 cnt_wrap;

  assign cnt_wrap = (cnt_q == rtc_cnt_w'(rtc_half_period - 1));

  // Toggle once per half period
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else if (cnt_wrap) begin
      cnt_q <= '0;
      rtc_q <= !rtc_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign rtc_o = rtc_q;

  // Counter stays inside its half period
  assert property (@(posedge soc_clk) disable iff (!rst_n)
    cnt_q <= rtc_cnt_w'(rtc_half_period - 1));

endmodule

/* logic/fan_ctrl.sv */
module fan_ctrl (
  input  logic       soc_clk,
  input  logic       rst_n,
  input  logic [3:0] pwm_setting_i,
  output logic       fan_pwm_o
);

  import board_pkg::*;

  logic [fan_pre_w-1:0] pre_q;
  logic [3:0]           step_q;
  logic [3:0]           setting_q;
  logic                 pwm_q;
  logic                 step_adv;
  logic                 period_end;

  assign step_adv   = (pre_q == fan_pre_w'(fan_prescale - 1));
  assign period_end = step_adv && (step_q == 4'hf);

  //////////////////////////////////////////////////
  // Prescaler and step counter
  //////////////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_q     <= '0;
      step_q    <= '0;
      setting_q <= '0;
    end else begin
      pre_q <= step_adv ? '0 : pre_q + 1'b1;
      if (step_adv) begin
        step_q <= step_q + 1'b1;
      end
      // New switch value only at a period boundary
      if (period_end) begin
        setting_q <= pwm_setting_i;
      end
    end
  end

  // High for the first setting steps of each period
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pwm_q <= 1'b0;
    end else begin
      pwm_q <= (step_q < setting_q);
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

/* logic/board_pads.sv */
module board_pads (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic spi_sck_i,
  input  logic spi_sck_en_i,
  input  logic spi_csb_i,
  input  logic spi_csb_en_i,
  input  logic spi_mosi_i,
  input  logic spi_mosi_en_i,
  output logic spi_miso_o,
  output logic sd_sclk_o,
  output logic sd_cmd_o,
  output logic sd_dat3_o,
  input  logic sd_dat0_i,
  input  logic sd_cd_i,
  output logic sd_cd_o,
  input  logic i2c_scl_i,
  input  logic i2c_scl_en_i,
  input  logic i2c_sda_i,
  input  logic i2c_sda_en_i,
  output logic i2c_scl_soc_o,
  output logic i2c_sda_soc_o,
  input  logic i2c_scl_pad_i,
  input  logic i2c_sda_pad_i,
  output logic i2c_scl_oe_o,
  output logic i2c_sda_oe_o
);

  import board_pkg::*;

  // Bit order per stage is {cd, sda, scl}
  logic [sync_stages-1:0][2:0] sync_q;

  // SD card in SPI mode, idle high when the host releases a pin
  assign sd_sclk_o  = spi_sck_en_i  ? spi_sck_i  : 1'b1;
  assign sd_dat3_o  = spi_csb_en_i  ? spi_csb_i  : 1'b1;
  assign sd_cmd_o   = spi_mosi_en_i ? spi_mosi_i : 1'b1;
  assign spi_miso_o = sd_dat0_i;

  // Open drain, pull low only for a driven zero
  assign i2c_scl_oe_o = i2c_scl_en_i && !i2c_scl_i;
  assign i2c_sda_oe_o = i2c_sda_en_i && !i2c_sda_i;

  //////////////////////////////////////////////////
  // Input synchronizers
  //////////////////////////////////////////////////

  // I2C lines idle high, card detect idles low
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= {sync_stages{3'b011}};
    end else begin
      sync_q <= {sync_q[sync_stages-2:0], {sd_cd_i, i2c_sda_pad_i, i2c_scl_pad_i}};
    end
  end

  assign i2c_scl_soc_o = sync_q[sync_stages-1][0];
  assign i2c_sda_soc_o = sync_q[sync_stages-1][1];
  assign sd_cd_o       = sync_q[sync_stages-1][2];

endmodule

/* logic/board_top.sv */
module board_top (
  input  logic                soc_clk,
  input  logic                rst_n,
  input  board_pkg::soc_req_t  soc_req_i,
  input  logic                soc_req_valid_i,
  output logic                soc_req_ready_o,
  output board_pkg::mem_rsp_t  soc_rsp_o,
  output logic                soc_rsp_valid_o,
  input  logic                soc_rsp_ready_i,
  output board_pkg::dram_req_t dram_req_o,
  output logic                dram_req_valid_o,
  input  logic                dram_req_ready_i,
  input  board_pkg::mem_rsp_t  dram_rsp_i,
  input  logic                dram_rsp_valid_i,
  output logic                dram_rsp_ready_o,
  output logic                rtc_o,
  input  logic [3:0]          fan_sw_i,
  output logic                fan_pwm_o,
  input  logic                spi_sck_i,
  input  logic                spi_sck_en_i,
  input  logic                spi_csb_i,
  input  logic                spi_csb_en_i,
  input  logic                spi_mosi_i,
  input  logic                spi_mosi_en_i,
  output logic                spi_miso_o,
  output logic                sd_sclk_o,
  output logic                sd_cmd_o,
  output logic                sd_dat3_o,
  input  logic                sd_dat0_i,
  input  logic                sd_cd_i,
  output logic                sd_cd_o,
  input  logic                i2c_scl_i,
  input  logic                i2c_scl_en_i,
  input  logic                i2c_sda_i,
  input  logic                i2c_sda_en_i,
  output logic                i2c_scl_soc_o,
  output logic                i2c_sda_soc_o,
  input  logic                i2c_scl_pad_i,
  input  logic                i2c_sda_pad_i,
  output logic                i2c_scl_oe_o,
  output logic                i2c_sda_oe_o
);

  import board_pkg::*;

  //////////////////////////////////////////////////
  // Memory path
  //////////////////////////////////////////////////

  // DRAM only sees the low address window
  dram_req_t req_narrow;

  assign req_narrow = '{
    addr:  soc_req_i.addr[dram_addr_w-1:0],
    we:    soc_req_i.we,
    wdata: soc_req_i.wdata,
    strb:  soc_req_i.strb
  };

  spill_cut #(
    .payload_t ( dram_req_t )
  ) i_req_cut (
    .soc_clk     ( soc_clk          ),
    .rst_n       ( rst_n            ),
    .in_data_i   ( req_narrow       ),
    .in_valid_i  ( soc_req_valid_i  ),
    .in_ready_o  ( soc_req_ready_o  ),
    .out_data_o  ( dram_req_o       ),
    .out_valid_o ( dram_req_valid_o ),
    .out_ready_i ( dram_req_ready_i )
  );

  spill_cut #(
    .payload_t ( mem_rsp_t )
  ) i_rsp_cut (
    .soc_clk     ( soc_clk          ),
    .rst_n       ( rst_n            ),
    .in_data_i   ( dram_rsp_i       ),
    .in_valid_i  ( dram_rsp_valid_i ),
    .in_ready_o  ( dram_rsp_ready_o ),
    .out_data_o  ( soc_rsp_o        ),
    .out_valid_o ( soc_rsp_valid_o  ),
    .out_ready_i ( soc_rsp_ready_i  )
  );

  //////////////////////////////////////////////////
  // RTC, fan and pads
  //////////////////////////////////////////////////

  rtc_divider i_rtc_divider (
    .soc_clk ( soc_clk ),
    .rst_n   ( rst_n   ),
    .rtc_o   ( rtc_o   )
  );

  fan_ctrl i_fan_ctrl (
    .soc_clk       ( soc_clk   ),
    .rst_n         ( rst_n     ),
    .pwm_setting_i ( fan_sw_i  ),
    .fan_pwm_o     ( fan_pwm_o )
  );

  board_pads i_board_pads (
    .soc_clk       ( soc_clk       ),
    .rst_n         ( rst_n         ),
    .spi_sck_i     ( spi_sck_i     ),
    .spi_sck_en_i  ( spi_sck_en_i  ),
    .spi_csb_i     ( spi_csb_i     ),
    .spi_csb_en_i  ( spi_csb_en_i  ),
    .spi_mosi_i    ( spi_mosi_i    ),
    .spi_mosi_en_i ( spi_mosi_en_i ),
    .spi_miso_o    ( spi_miso_o    ),
    .sd_sclk_o     ( sd_sclk_o     ),
    .sd_cmd_o      ( sd_cmd_o      ),
    .sd_dat3_o     ( sd_dat3_o     ),
    .sd_dat0_i     ( sd_dat0_i     ),
    .sd_cd_i       ( sd_cd_i       ),
    .sd_cd_o       ( sd_cd_o       ),
    .i2c_scl_i     ( i2c_scl_i     ),
    .i2c_scl_en_i  ( i2c_scl_en_i  ),
    .i2c_sda_i     ( i2c_sda_i     ),
    .i2c_sda_en_i  ( i2c_sda_en_i  ),
    .i2c_scl_soc_o ( i2c_scl_soc_o ),
    .i2c_sda_soc_o ( i2c_sda_soc_o ),
    .i2c_scl_pad_i ( i2c_scl_pad_i ),
    .i2c_sda_pad_i ( i2c_sda_pad_i ),
    .i2c_scl_oe_o  ( i2c_scl_oe_o  ),
    .i2c_sda_oe_o  ( i2c_sda_oe_o  )
  );

endmodule

/* sim/board_top_tb.sv */
module board_top_tb;

  import board_pkg::*;

  // The tests take well under 1500 cycles
  localparam int max_cycles = 5000;

  logic       soc_clk;
  logic       rst_n;
  soc_req_t   soc_req_i;
  logic       soc_req_valid_i;
  logic       soc_req_ready_o;
  mem_rsp_t   soc_rsp_o;
  logic       soc_rsp_valid_o;
  logic       soc_rsp_ready_i;
  dram_req_t  dram_req_o;
  logic       dram_req_valid_o;
  logic       dram_req_ready_i;
  mem_rsp_t   dram_rsp_i;
  logic       dram_rsp_valid_i;
  logic       dram_rsp_ready_o;
  logic       rtc_o;
  logic [3:0] fan_sw_i;
  logic       fan_pwm_o;
  logic       spi_sck_i;
  logic       spi_sck_en_i;
  logic       spi_csb_i;
  logic       spi_csb_en_i;
  logic       spi_mosi_i;
  logic       spi_mosi_en_i;
  logic       spi_miso_o;
  logic       sd_sclk_o;
  logic       sd_cmd_o;
  logic       sd_dat3_o;
  logic       sd_dat0_i;
  logic       sd_cd_i;
  logic       sd_cd_o;
  logic       i2c_scl_i;
  logic       i2c_scl_en_i;
  logic       i2c_sda_i;
  logic       i2c_sda_en_i;
  logic       i2c_scl_soc_o;
  logic       i2c_sda_soc_o;
  logic       i2c_scl_pad_i;
  logic       i2c_sda_pad_i;
  logic       i2c_scl_oe_o;
  logic       i2c_sda_oe_o;

  logic [31:0] rng_state;
  int          cycle_cnt = 0;
  int          test_cnt = 0;
  int          failed_tests = 0;
  int          fail_cnt = 0;
  int          test_fails;
  string       test_name;

  // Expected beats in the order they were sent
  dram_req_t req_exp_q[$];
  mem_rsp_t  rsp_exp_q[$];

  board_top board_top_inst (.*);

  initial begin
    soc_clk = 1'b0;
    forever #4 soc_clk = ~soc_clk;
  end

  always @(posedge soc_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("Timeout, the tests did not finish within %0d cycles", max_cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
  endfunction

  function automatic soc_req_t rand_req();
    soc_req_t    r;
    logic [31:0] hi;
    hi = next_rand();
    r.addr  = {hi[15:0], next_rand()};
    r.we    = hi[16];
    r.wdata = {next_rand(), next_rand()};
    r.strb  = hi[31:24];
    return r;
  endfunction

  // DRAM sees the low 30 address bits, all else unchanged
  function automatic dram_req_t narrow_req(input soc_req_t r);
    dram_req_t d;
    d.addr  = r.addr[dram_addr_w-1:0];
    d.we    = r.we;
    d.wdata = r.wdata;
    d.strb  = r.strb;
    return d;
  endfunction

  task automatic report_mismatch(input logic [127:0] want, input logic [127:0] got);
    fail_cnt++;
    test_fails++;
    $display("[FAIL] %s: expected %0h, actual %0h", test_name, want, got);
  endtask

  task automatic start_test(input string name);
    test_name  = name;
    test_fails = 0;
  endtask

  task automatic finish_test();
    test_cnt++;
    if (test_fails == 0) begin
      $display("%s: ok", test_name);
    end else begin
      failed_tests++;
      $display("%s: %0d mismatches", test_name, test_fails);
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_req(input soc_req_t r);
    soc_req_i       = r;
    soc_req_valid_i = 1'b1;
    while (!soc_req_ready_o) begin
      @(negedge soc_clk);
    end
    @(negedge soc_clk);
    soc_req_valid_i = 1'b0;
  endtask

  task automatic send_rsp(input mem_rsp_t b);
    dram_rsp_i       = b;
    dram_rsp_valid_i = 1'b1;
    while (!dram_rsp_ready_o) begin
      @(negedge soc_clk);
    end
    @(negedge soc_clk);
    dram_rsp_valid_i = 1'b0;
  endtask

  task automatic collect_req(input int n);
    int        got;
    dram_req_t want;
    got = 0;
    dram_req_ready_i = 1'b1;
    while (got < n) begin
      if (dram_req_valid_o) begin
        want = req_exp_q.pop_front();
        if (dram_req_o !== want) report_mismatch(128'(want), 128'(dram_req_o));
        got++;
      end
      @(negedge soc_clk);
    end
  endtask

  // Ready toggles following a random bit pattern
  task automatic collect_rsp(input int n, input logic [31:0] ready_pat);
    int       got;
    int       cyc;
    mem_rsp_t want;
    got = 0;
    cyc = 0;
    while (got < n) begin
      soc_rsp_ready_i = ready_pat[cyc % 32];
      if (soc_rsp_valid_o && soc_rsp_ready_i) begin
        want = rsp_exp_q.pop_front();
        if (soc_rsp_o !== want) report_mismatch(128'(want), 128'(soc_rsp_o));
        got++;
      end
      cyc++;
      @(negedge soc_clk);
    end
    soc_rsp_ready_i = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_req_order();
    soc_req_t reqs[$];
    start_test("req_order");
    for (int i = 0; i < 8; i++) begin
      reqs.push_back(rand_req());
      req_exp_q.push_back(narrow_req(reqs[i]));
    end
    fork
      begin
        foreach (reqs[i]) begin
          send_req(reqs[i]);
        end
      end
      collect_req(8);
    join
    finish_test();
  endtask

  task automatic test_backpressure();
    soc_req_t reqs[$];
    start_test("backpressure");
    dram_req_ready_i = 1'b0;
    for (int i = 0; i < 4; i++) begin
      reqs.push_back(rand_req());
      req_exp_q.push_back(narrow_req(reqs[i]));
    end
    // Both slots fill, then ready must stay low
    send_req(reqs[0]);
    send_req(reqs[1]);
    soc_req_i       = reqs[2];
    soc_req_valid_i = 1'b1;
    repeat (4) begin
      if (soc_req_ready_o !== 1'b0) report_mismatch(128'(1'b0), 128'(soc_req_ready_o));
      @(negedge soc_clk);
    end
    fork
      begin
        send_req(reqs[2]);
        send_req(reqs[3]);
      end
      collect_req(4);
    join
    finish_test();
  endtask

  task automatic test_rsp_path();
    mem_rsp_t    beats[$];
    mem_rsp_t    b;
    logic [31:0] ready_pat;
    start_test("rsp_path");
    for (int i = 0; i < 10; i++) begin
      b.rdata = {next_rand(), next_rand()};
      b.err   = next_rand() > 32'hc000_0000;
      beats.push_back(b);
      rsp_exp_q.push_back(b);
    end
    ready_pat = next_rand() | 32'h1111_1111;
    fork
      begin
        foreach (beats[i]) begin
          send_rsp(beats[i]);
        end
      end
      collect_rsp(10, ready_pat);
    join
    finish_test();
  endtask

  task automatic test_rtc();
    logic prev;
    int   len;
    start_test("rtc");
    prev = rtc_o;
    while (rtc_o == prev) begin
      @(negedge soc_clk);
    end
    for (int k = 0; k < 4; k++) begin
      prev = rtc_o;
      len  = 0;
      while (rtc_o == prev) begin
        @(negedge soc_clk);
        len++;
      end
      if (len != rtc_half_period) report_mismatch(128'(rtc_half_period), 128'(len));
    end
    finish_test();
  endtask

  task automatic test_fan();
    int settings[3] = '{0, 5, 15};
    int highs;
    start_test("fan_pwm");
    foreach (settings[s]) begin
      fan_sw_i = 4'(settings[s]);
      // New setting is latched at the next period boundary
      repeat (64) @(negedge soc_clk);
      highs = 0;
      repeat (64) begin
        if (fan_pwm_o) highs++;
        @(negedge soc_clk);
      end
      if (highs != settings[s] * fan_prescale) begin
        report_mismatch(128'(settings[s] * fan_prescale), 128'(highs));
      end
    end
    finish_test();
  endtask

  task automatic test_pads();
    logic [5:0] spi;
    logic [3:0] want_sd;
    logic [1:0] want_oe;
    logic [2:0] pads;
    logic [2:0] prev;
    start_test("pads");
    for (int i = 0; i < 64; i++) begin
      spi = 6'(i);
      {spi_sck_en_i, spi_csb_en_i, spi_mosi_en_i, spi_sck_i, spi_csb_i, spi_mosi_i} = spi;
      sd_dat0_i = spi[0] ^ spi[5];
      {i2c_scl_en_i, i2c_scl_i, i2c_sda_en_i, i2c_sda_i} = spi[3:0];
      // Released SD pins idle high
      want_sd[3] = spi[5] ? spi[2] : 1'b1;
      want_sd[2] = spi[4] ? spi[1] : 1'b1;
      want_sd[1] = spi[3] ? spi[0] : 1'b1;
      want_sd[0] = spi[0] ^ spi[5];
      want_oe = {spi[3] & ~spi[2], spi[1] & ~spi[0]};
      @(posedge soc_clk);
      if ({sd_sclk_o, sd_dat3_o, sd_cmd_o, spi_miso_o} !== want_sd) begin
        report_mismatch(128'(want_sd), 128'({sd_sclk_o, sd_dat3_o, sd_cmd_o, spi_miso_o}));
      end
      if ({i2c_scl_oe_o, i2c_sda_oe_o} !== want_oe) begin
        report_mismatch(128'(want_oe), 128'({i2c_scl_oe_o, i2c_sda_oe_o}));
      end
      @(negedge soc_clk);
    end
    // Order is {cd, sda, scl}
    prev = 3'b011;
    for (int j = 0; j < 8; j++) begin
      pads = 3'(next_rand());
      {sd_cd_i, i2c_sda_pad_i, i2c_scl_pad_i} = pads;
      @(negedge soc_clk);
      if ({sd_cd_o, i2c_sda_soc_o, i2c_scl_soc_o} !== prev) begin
        report_mismatch(128'(prev), 128'({sd_cd_o, i2c_sda_soc_o, i2c_scl_soc_o}));
      end
      @(negedge soc_clk);
      if ({sd_cd_o, i2c_sda_soc_o, i2c_scl_soc_o} !== pads) begin
        report_mismatch(128'(pads), 128'({sd_cd_o, i2c_sda_soc_o, i2c_scl_soc_o}));
      end
      prev = pads;
    end
    finish_test();
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    rng_state        = 32'h6c531c68;
    rst_n            = 1'b0;
    soc_req_i        = '0;
    soc_req_valid_i  = 1'b0;
    soc_rsp_ready_i  = 1'b0;
    dram_req_ready_i = 1'b0;
    dram_rsp_i       = '0;
    dram_rsp_valid_i = 1'b0;
    fan_sw_i         = 4'd0;
    spi_sck_i        = 1'b0;
    spi_sck_en_i     = 1'b0;
    spi_csb_i        = 1'b1;
    spi_csb_en_i     = 1'b0;
    spi_mosi_i       = 1'b0;
    spi_mosi_en_i    = 1'b0;
    sd_dat0_i        = 1'b1;
    sd_cd_i          = 1'b0;
    i2c_scl_i        = 1'b1;
    i2c_scl_en_i     = 1'b0;
    i2c_sda_i        = 1'b1;
    i2c_sda_en_i     = 1'b0;
    i2c_scl_pad_i    = 1'b1;
    i2c_sda_pad_i    = 1'b1;
    repeat (5) @(negedge soc_clk);
    rst_n = 1'b1;
    @(negedge soc_clk);

    test_req_order();
    test_backpressure();
    test_rsp_path();
    test_rtc();
    test_fan();
    test_pads();

    $display("%0d tests, %0d failed, %0d mismatches", test_cnt, failed_tests, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* board_top.f */
logic/board_pkg.sv
logic/spill_cut.sv
logic/rtc_divider.sv
logic/fan_ctrl.sv
logic/board_pads.sv
logic/board_top.sv
sim/board_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the board testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module board_top_tb \
  -f board_top.f \
  -o board_top_sim || { echo "build failed"; exit 1; }

./obj_dir/board_top_sim > sim.log 2>&1

grep -q "TESTS PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
